// ==== design/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                        clk,
    input  logic                        resetn,
    req_stage_if.sink                   req,
    mem_rd_if.master                    rd,
    input  logic [`WAY_NUM-1:0]         hit_way,
    output logic                        fill,
    output logic [$clog2(`WAY_NUM)-1:0] fill_way,
    output logic                        inval,
    output logic [$clog2(`WAY_NUM)-1:0] inval_way,
    input  logic [`LINE_WIDTH-1:0]      way0_line,
    input  logic [`LINE_WIDTH-1:0]      way1_line,
    output logic                        data_ok,
    output logic [31:0]                 rdata,
    output logic [`WAY_NUM-1:0]         ram_we
);

    localparam int WAY_BITS = $clog2(`WAY_NUM);

    ctrl_state_e              state_q;
    ctrl_state_e              state;
    logic                     lookup;
    logic                     is_read;
    logic                     is_idx;
    logic                     hit;
    logic                     read_hit;
    logic                     need_mem;
    logic                     refill_done;
    logic [WAY_BITS-1:0]      hit_idx;
    logic [WAY_BITS-1:0]      rr_way;
    logic [`OFFSET_WIDTH-3:0] word_sel;
    logic [`LINE_WIDTH-1:0]   hit_line;

    // lookup is entered through the front's request register
    always_comb begin
        state = state_q;
        if (state_q == ST_IDLE && req.req_valid) begin
            state = ST_LOOKUP;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
        end else begin
            case (state)
                ST_LOOKUP: begin
                    if (need_mem) begin
                        state_q <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (rd.done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign lookup      = (state == ST_LOOKUP);
    assign is_read     = (req.op_class == OP_CLASS_READ);
    assign is_idx      = (req.op_class == OP_CLASS_CACOP_IDX);
    assign hit         = |hit_way;
    assign read_hit    = lookup & is_read & ~req.uncached & hit;
    assign need_mem    = lookup & is_read & (req.uncached | ~hit);
    assign refill_done = (state == ST_REFILL) & rd.done;

    // a hit or a cache op frees the stage in its own cycle
    assign req.accept_ok = (state == ST_IDLE) | read_hit | (lookup & ~is_read);

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < `WAY_NUM; w++) begin
            if (hit_way[w]) begin
                hit_idx = WAY_BITS'(w);
            end
        end
    end

    // index op takes the way from the low address bits
    assign inval = lookup & (is_idx | ((req.op_class == OP_CLASS_CACOP_HIT) & hit));
    assign inval_way = is_idx ? req.addr.f.offset[WAY_BITS-1:0] : hit_idx;

    assign rd.start     = need_mem;
    assign rd.uncached  = req.uncached;
    assign rd.line_addr = req.addr;

    // refill goes to the round-robin way
    assign fill     = refill_done & ~req.uncached;
    assign fill_way = rr_way;

    always_comb begin
        for (int w = 0; w < `WAY_NUM; w++) begin
            ram_we[w] = fill & (rr_way == WAY_BITS'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rr_way <= '0;
        end else if (fill) begin
            rr_way <= rr_way + 1'b1;
        end
    end

    assign data_ok  = read_hit | refill_done;
    assign hit_line = hit_way[1] ? way1_line : way0_line;
    assign word_sel = req.addr.f.offset[`OFFSET_WIDTH-1:2];

    always_comb begin
        if (lookup) begin
            rdata = hit_line[word_sel*32 +: 32];
        end else if (req.uncached) begin
            rdata = rd.word;
        end else begin
            rdata = rd.line[word_sel*32 +: 32];
        end
    end

endmodule

// ==== design/icache_data_ram.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_data_ram #(
    parameter int DEPTH = 1 << `INDEX_WIDTH
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     we,
    input  logic [`LINE_WIDTH-1:0]   wdata,
    output logic [`LINE_WIDTH-1:0]   rdata
);

    logic [`LINE_WIDTH-1:0] mem [DEPTH];

    // read returns the old line on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== design/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// address split, 16-byte lines and 256 sets
`define TAG_WIDTH     20
`define INDEX_WIDTH   8
`define OFFSET_WIDTH  4

// line geometry
`define LINE_WIDTH    128
`define LINE_WORDS    4
`define WAY_NUM       2

// read types toward memory
`define RD_TYPE_WORD  3'd2
`define RD_TYPE_LINE  3'd4

// pipe op codes, casez patterns
`define OP_READ       3'b000
// 4 and 5 are both index invalidate
`define OP_CACOP_IDX  3'b10?
`define OP_CACOP_HIT  3'b110

`endif

// ==== design/icache_if.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

// request register toward the lookup logic
interface req_stage_if import icache_pkg::*;;

    logic                    req_valid;
    op_class_e               op_class;
    cache_addr_u             addr;
    logic                    uncached;
    // array read index, live on the accept edge
    logic [`INDEX_WIDTH-1:0] rd_index;
    logic                    accept_ok;

    modport source (
        output req_valid, op_class, addr, uncached, rd_index,
        input  accept_ok
    );

    modport sink (
        input  req_valid, op_class, addr, uncached,
        output accept_ok
    );

endinterface

// one memory read, started by ctrl
interface mem_rd_if import icache_pkg::*;;

    logic                   start;
    logic                   uncached;
    cache_addr_u            line_addr;
    logic                   done;
    logic [`LINE_WIDTH-1:0] line;
    logic [31:0]            word;

    modport master (output start, uncached, line_addr, input done, line, word);

    modport slave (input start, uncached, line_addr, output done, line, word);

endinterface

// ==== design/icache_mem_read.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_mem_read import icache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    mem_rd_if.slave     rd,
    output logic        rd_req,
    output logic [2:0]  rd_type,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] ret_data
);

    localparam int BEAT_BITS = $clog2(`LINE_WORDS);

    logic                   req_q;
    logic                   busy_q;
    logic                   unc_q;
    cache_addr_u            addr_q;
    logic [BEAT_BITS-1:0]   beat_q;
    logic [`LINE_WIDTH-1:0] line_q;
    logic [`LINE_WIDTH-1:0] line_next;

    // request held until the memory side takes it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_q  <= 1'b0;
            busy_q <= 1'b0;
            beat_q <= '0;
        end else begin
            if (rd.start) begin
                req_q  <= 1'b1;
                busy_q <= 1'b1;
                beat_q <= '0;
            end else begin
                if (req_q && rd_rdy) begin
                    req_q <= 1'b0;
                end
                if (busy_q && ret_valid) begin
                    beat_q <= beat_q + 1'b1;
                    if (ret_last) begin
                        busy_q <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd.start) begin
            unc_q  <= rd.uncached;
            addr_q <= rd.line_addr;
        end
        if (busy_q && ret_valid) begin
            line_q <= line_next;
        end
    end

    // beats arrive from word 0 upward
    always_comb begin
        line_next = line_q;
        line_next[beat_q*32 +: 32] = ret_data;
    end

    assign rd_req  = req_q;
    assign rd_type = unc_q ? `RD_TYPE_WORD : `RD_TYPE_LINE;
    assign rd_addr = unc_q ? addr_q.flat : {addr_q.f.tag, addr_q.f.index, {`OFFSET_WIDTH{1'b0}}};

    assign rd.done = busy_q & ret_valid & ret_last;
    assign rd.line = line_next;
    assign rd.word = ret_data;

endmodule

// ==== design/icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

    // field view of an address
    typedef struct packed {
        logic [`TAG_WIDTH-1:0]    tag;
        logic [`INDEX_WIDTH-1:0]  index;
        logic [`OFFSET_WIDTH-1:0] offset;
    } cache_addr_fields_t;

    // flat for memory, fields for lookup
    typedef union packed {
        logic [31:0]        flat;
        cache_addr_fields_t f;
    } cache_addr_u;

    typedef enum logic [1:0] {
        OP_CLASS_READ,
        OP_CLASS_CACOP_IDX,
        OP_CLASS_CACOP_HIT
    } op_class_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } ctrl_state_e;

endpackage

// ==== design/icache_req_front.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_req_front import icache_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  logic [2:0]  op,
    input  logic [31:0] addr,
    input  logic        uncached,
    output logic        addr_ok,
    req_stage_if.source req
);

    cache_addr_u pipe_addr;
    op_class_e   op_class_d;

    assign pipe_addr.flat = addr;

    // taken only when ctrl has room
    assign addr_ok = valid & req.accept_ok;

    always_comb begin
        casez (op)
            `OP_READ:      op_class_d = OP_CLASS_READ;
            `OP_CACOP_IDX: op_class_d = OP_CLASS_CACOP_IDX;
            `OP_CACOP_HIT: op_class_d = OP_CLASS_CACOP_HIT;
            // unsupported ops behave as reads
            default:       op_class_d = OP_CLASS_READ;
        endcase
    end

    // lookup cycle follows the accept edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req.req_valid <= 1'b0;
        end else begin
            req.req_valid <= addr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req.op_class <= op_class_d;
            req.addr     <= pipe_addr;
            req.uncached <= uncached;
        end
    end

    // arrays read the new index on accept, else keep the held one
    assign req.rd_index = addr_ok ? pipe_addr.f.index : req.addr.f.index;

endmodule

// ==== design/icache_tag_store.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_tag_store (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic [`INDEX_WIDTH-1:0]     rd_index,
    input  logic [`TAG_WIDTH-1:0]       req_tag,
    input  logic                        fill,
    input  logic [$clog2(`WAY_NUM)-1:0] fill_way,
    input  logic [`INDEX_WIDTH-1:0]     fill_index,
    input  logic                        inval,
    input  logic [$clog2(`WAY_NUM)-1:0] inval_way,
    output logic [`WAY_NUM-1:0]         hit_way
);

    localparam int SETS     = 1 << `INDEX_WIDTH;
    localparam int WAY_BITS = $clog2(`WAY_NUM);

    logic [`WAY_NUM-1:0][SETS-1:0] valid_q;

    // valid bits in flops, cleared as a whole
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[fill_way][fill_index] <= 1'b1;
        end else if (inval) begin
            valid_q[inval_way][fill_index] <= 1'b0;
        end
    end

    for (genvar w = 0; w < `WAY_NUM; w++) begin : g_way
        logic [`TAG_WIDTH-1:0] tags [SETS];
        logic [`TAG_WIDTH-1:0] tag_q;

        always_ff @(posedge clk) begin
            if (fill && fill_way == WAY_BITS'(w)) begin
                tags[fill_index] <= req_tag;
            end
            tag_q <= tags[rd_index];
        end

        // stored tag against the held request tag
        assign hit_way[w] = valid_q[w][fill_index] & (tag_q == req_tag);
    end

endmodule

// ==== design/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top (
    input  logic        clk,
    input  logic        resetn,
    input  logic        valid,
    input  logic [2:0]  op,
    input  logic [31:0] addr,
    input  logic        uncached,
    output logic        addr_ok,
    output logic        data_ok,
    output logic [31:0] rdata,
    output logic        rd_req,
    output logic [2:0]  rd_type,
    output logic [31:0] rd_addr,
    input  logic        rd_rdy,
    input  logic        ret_valid,
    input  logic        ret_last,
    input  logic [31:0] ret_data
);

    localparam int WAY_BITS = $clog2(`WAY_NUM);

    logic [`WAY_NUM-1:0]    hit_way;
    logic                   fill;
    logic [WAY_BITS-1:0]    fill_way;
    logic                   inval;
    logic [WAY_BITS-1:0]    inval_way;
    logic [`WAY_NUM-1:0]    ram_we;
    logic [`LINE_WIDTH-1:0] way0_line;
    logic [`LINE_WIDTH-1:0] way1_line;

    req_stage_if req_if ();
    mem_rd_if    rd_if ();

    icache_req_front u_front (
        .clk      (clk),
        .resetn   (resetn),
        .valid    (valid),
        .op       (op),
        .addr     (addr),
        .uncached (uncached),
        .addr_ok  (addr_ok),
        .req      (req_if.source)
    );

    icache_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req_if.sink),
        .rd        (rd_if.master),
        .hit_way   (hit_way),
        .fill      (fill),
        .fill_way  (fill_way),
        .inval     (inval),
        .inval_way (inval_way),
        .way0_line (way0_line),
        .way1_line (way1_line),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .ram_we    (ram_we)
    );

    icache_tag_store u_tags (
        .clk        (clk),
        .resetn     (resetn),
        .rd_index   (req_if.rd_index),
        .req_tag    (req_if.addr.f.tag),
        .fill       (fill),
        .fill_way   (fill_way),
        .fill_index (req_if.addr.f.index),
        .inval      (inval),
        .inval_way  (inval_way),
        .hit_way    (hit_way)
    );

    icache_data_ram #(.DEPTH(1 << `INDEX_WIDTH)) u_way0_ram (
        .clk   (clk),
        .addr  (req_if.rd_index),
        .we    (ram_we[0]),
        .wdata (rd_if.line),
        .rdata (way0_line)
    );

    icache_data_ram #(.DEPTH(1 << `INDEX_WIDTH)) u_way1_ram (
        .clk   (clk),
        .addr  (req_if.rd_index),
        .we    (ram_we[1]),
        .wdata (rd_if.line),
        .rdata (way1_line)
    );

    icache_mem_read u_mem_read (
        .clk       (clk),
        .resetn    (resetn),
        .rd        (rd_if.slave),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

endmodule

// ==== icache_top.f ====
+incdir+design
design/icache_pkg.sv
design/icache_if.sv
design/icache_req_front.sv
design/icache_ctrl.sv
design/icache_tag_store.sv
design/icache_data_ram.sv
design/icache_mem_read.sv
design/icache_top.sv
verif/icache_assertions.sv
verif/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    -f icache_top.f \
    --top-module tb_icache \
    -Mdir obj_dir &&
./obj_dir/Vtb_icache || {
    echo "simulation failed"
    exit 1
}

// ==== verif/icache_assertions.sv ====
`timescale 1ns/1ps

module icache_assertions (
    input logic        clk,
    input logic        resetn,
    input logic [2:0]  op,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        rd_req,
    input logic [31:0] rd_addr,
    input logic        rd_rdy
);

    logic       read_op;
    logic [1:0] open_reads;

    // ops 4, 5 and 6 are cache ops and the rest read
    assign read_op = !(op inside {3'd4, 3'd5, 3'd6});

    // reads accepted but not yet answered
    always_ff @(posedge clk) begin
        if (!resetn) begin
            open_reads <= '0;
        end else begin
            open_reads <= open_reads + 2'(addr_ok & read_op) - 2'(data_ok);
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
        else $error("rd_req dropped or rd_addr moved before rd_rdy");

    a_data_ok_owned: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> open_reads != 2'd0)
        else $error("data_ok without an open read");

    a_reset_quiet: assert property (@(posedge clk)
        !resetn |=> !addr_ok && !data_ok && !rd_req)
        else $error("handshake outputs active right after reset");

endmodule

bind icache_top icache_assertions u_assertions (
    .clk     (clk),
    .resetn  (resetn),
    .op      (op),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_rdy  (rd_rdy)
);

// ==== verif/tb_icache.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module tb_icache;

    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic        unc;
        logic        miss;
        logic        dok;
    } row_t;

    // one accepted request waiting for its answer
    typedef struct packed {
        row_t r;
        int   cnt;
        int   cyc;
    } pend_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    logic [2:0]  op;
    logic [31:0] addr;
    logic        uncached;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [2:0]  rd_type;
    logic [31:0] rd_addr;
    logic        rd_rdy = 1'b0;
    logic        ret_valid = 1'b0;
    logic        ret_last = 1'b0;
    logic [31:0] ret_data = '0;

    integer      seed = 32'h8644;
    int          req_count = 0;
    logic [31:0] req_addr = '0;
    logic [2:0]  req_type = '0;
    int          rdy_wait = -1;
    int          beats_left = 0;
    int          gap = 0;
    logic [31:0] beat_addr = '0;
    int          cyc = 0;

    row_t                  rows[$];
    pend_t                 pend_q[$];
    logic [`TAG_WIDTH-1:0] ref_tag [`WAY_NUM][1 << `INDEX_WIDTH];
    bit                    ref_valid [`WAY_NUM][1 << `INDEX_WIDTH];
    int                    ref_rr = 0;

    icache_top dut0 (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .uncached  (uncached),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] model_word(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // memory model with random rd_rdy delay and random beat gaps
    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy     <= 1'b0;
            ret_valid  <= 1'b0;
            ret_last   <= 1'b0;
            rdy_wait   = -1;
            beats_left = 0;
        end else begin
            rd_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (rd_req && rd_rdy) begin
                req_count  <= req_count + 1;
                req_addr   <= rd_addr;
                req_type   <= rd_type;
                beat_addr  = rd_addr;
                beats_left = (rd_type == `RD_TYPE_LINE) ? `LINE_WORDS : 1;
                gap        = $random(seed) & 3;
                rdy_wait   = -1;
            end else if (rd_req && beats_left == 0) begin
                if (rdy_wait < 0) begin
                    rdy_wait = $random(seed) & 3;
                end
                if (rdy_wait == 0) begin
                    rd_rdy <= 1'b1;
                end else begin
                    rdy_wait = rdy_wait - 1;
                end
            end else if (beats_left > 0) begin
                if (gap > 0) begin
                    gap = gap - 1;
                end else begin
                    ret_valid  <= 1'b1;
                    ret_data   <= model_word(beat_addr);
                    ret_last   <= (beats_left == 1);
                    beat_addr  = beat_addr + 32'd4;
                    beats_left = beats_left - 1;
                    gap        = $random(seed) & 1;
                end
            end
        end
    end

    task automatic stop_with_fail(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic add_row(input logic [2:0] o, input logic [31:0] a, input logic u,
                           input logic m, input logic d);
        rows.push_back(row_t'{o, a, u, m, d});
    endtask

    // expected miss from tags, valid bits and a global round-robin fill way
    task automatic ref_update(input row_t r, output logic miss);
        logic [`INDEX_WIDTH-1:0] idx;
        logic [`TAG_WIDTH-1:0]   tg;
        logic                    hit0;
        logic                    hit1;
        idx  = r.addr[`OFFSET_WIDTH +: `INDEX_WIDTH];
        tg   = r.addr[31 -: `TAG_WIDTH];
        hit0 = ref_valid[0][idx] && ref_tag[0][idx] == tg;
        hit1 = ref_valid[1][idx] && ref_tag[1][idx] == tg;
        miss = 1'b0;
        if (r.op == 3'd4 || r.op == 3'd5) begin
            ref_valid[r.addr[0]][idx] = 1'b0;
        end else if (r.op == 3'd6) begin
            if (hit0) ref_valid[0][idx] = 1'b0;
            if (hit1) ref_valid[1][idx] = 1'b0;
        end else begin
            miss = r.unc || !(hit0 || hit1);
            if (miss && !r.unc) begin
                ref_tag[ref_rr][idx]   = tg;
                ref_valid[ref_rr][idx] = 1'b1;
                ref_rr = (ref_rr + 1) % `WAY_NUM;
            end
        end
    endtask

    task automatic check_response();
        pend_t       p;
        logic [31:0] exp_addr;
        logic [2:0]  exp_type;
        if (pend_q.size() != 0 && !pend_q[0].r.dok) begin
            // cache op finishes in its lookup cycle
            assert (!data_ok) else
                stop_with_fail($sformatf("** Error at %0t: cache op at %h gave data_ok",
                                         $time, pend_q[0].r.addr));
            void'(pend_q.pop_front());
        end else if (data_ok) begin
            assert (pend_q.size() != 0) else
                stop_with_fail("data_ok arrived while no read was waiting");
            p = pend_q.pop_front();
            assert (rdata === model_word({p.r.addr[31:2], 2'b00})) else
                stop_with_fail($sformatf("** Error at %0t: read %h returned %h, expected %h",
                    $time, p.r.addr, rdata, model_word({p.r.addr[31:2], 2'b00})));
            if (p.r.miss) begin
                exp_addr = p.r.unc ? p.r.addr : {p.r.addr[31:4], 4'h0};
                exp_type = p.r.unc ? `RD_TYPE_WORD : `RD_TYPE_LINE;
                assert (req_count == p.cnt + 1 && req_addr == exp_addr &&
                        req_type == exp_type && ret_valid && ret_last) else
                    stop_with_fail($sformatf(
                        "** Error at %0t: miss %h made %0d requests, %h type %0d",
                        $time, p.r.addr, req_count - p.cnt, req_addr, req_type));
            end else begin
                assert (req_count == p.cnt && cyc == p.cyc + 1) else
                    stop_with_fail($sformatf("** Error at %0t: read %h expected a hit",
                                             $time, p.r.addr));
            end
        end
    endtask

    task automatic step();
        @(posedge clk);
        cyc++;
        check_response();
    endtask

    initial begin
        logic  miss;
        logic  accepted;
        pend_t p;
        resetn   = 1'b0;
        valid    = 1'b0;
        op       = 3'd0;
        addr     = '0;
        uncached = 1'b0;
        // op, address, uncached, miss, data_ok
        add_row(3'd0, 32'h0000_1010, 1'b0, 1'b1, 1'b1);
        add_row(3'd0, 32'h0000_1018, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_2024, 1'b1, 1'b1, 1'b1);
        add_row(3'd0, 32'h0000_2020, 1'b0, 1'b1, 1'b1);
        // three tags fighting over index 5
        add_row(3'd0, 32'h0000_3050, 1'b0, 1'b1, 1'b1);
        add_row(3'd0, 32'h0000_4054, 1'b0, 1'b1, 1'b1);
        add_row(3'd0, 32'h0000_3058, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_405c, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_5050, 1'b0, 1'b1, 1'b1);
        add_row(3'd0, 32'h0000_4050, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_3050, 1'b0, 1'b1, 1'b1);
        // invalidates by index and by hit
        add_row(3'd4, 32'h0000_0050, 1'b0, 1'b0, 1'b0);
        add_row(3'd0, 32'h0000_3054, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_5050, 1'b0, 1'b1, 1'b1);
        add_row(3'd5, 32'h0000_0051, 1'b0, 1'b0, 1'b0);
        add_row(3'd0, 32'h0000_5054, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_3050, 1'b0, 1'b1, 1'b1);
        add_row(3'd6, 32'h0000_1010, 1'b0, 1'b0, 1'b0);
        add_row(3'd0, 32'h0000_101c, 1'b0, 1'b1, 1'b1);
        add_row(3'd6, 32'h0000_9090, 1'b0, 1'b0, 1'b0);
        add_row(3'd0, 32'h0000_2028, 1'b0, 1'b0, 1'b1);
        // back-to-back hits with valid held high
        add_row(3'd0, 32'h0000_2020, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_3050, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_505c, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_1014, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_202c, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_abc4, 1'b0, 1'b1, 1'b1);
        add_row(3'd0, 32'h0001_2340, 1'b0, 1'b1, 1'b1);
        add_row(3'd0, 32'h0000_abc8, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 32'h0000_7778, 1'b1, 1'b1, 1'b1);
        add_row(3'd0, 32'h0001_2344, 1'b0, 1'b0, 1'b1);

        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        step();
        for (int i = 0; i < rows.size(); i++) begin
            ref_update(rows[i], miss);
            assert (miss == rows[i].miss) else
                stop_with_fail($sformatf("table row %0d disagrees with the reference model", i));
            valid    <= 1'b1;
            op       <= rows[i].op;
            addr     <= rows[i].addr;
            uncached <= rows[i].unc;
            accepted = 1'b0;
            for (int t = 0; t < 200 && !accepted; t++) begin
                step();
                accepted = addr_ok;
            end
            assert (accepted) else
                stop_with_fail($sformatf("timed out waiting for addr_ok on table row %0d", i));
            p = pend_t'{rows[i], req_count, cyc};
            pend_q.push_back(p);
        end
        valid <= 1'b0;
        for (int t = 0; t < 400 && pend_q.size() != 0; t++) begin
            step();
        end
        assert (pend_q.size() == 0) else
            stop_with_fail("timed out waiting for the last responses");
        $display("Result: PASSED");
        $finish;
    end

endmodule
